/* Makefile */
# Verilator build and run for the trellis front end testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := trellisFrontEndTb
FILELIST  := sources.f
OBJDIR    := obj_dir
LOG       := sim.log
PASSMSG   := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log search decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* rtl/branchRotator.sv */
/* Branch rotation bank
   truncates one complex branch and registers its four quadrant rotations */

`timescale 1ns/1ps

module branchRotator
   import trellisPkg::*;
#(
   parameter bit HalfScale = 1'b0
)
(
   input  logic     clk,
   input  logic     rst,
   input  logic     sampleEn,
   input  sample_t  re,
   input  sample_t  im,
   output rotBank_t rotReal,
   output rotBank_t rotImag
);

   rotSample_t baseRe;
   rotSample_t baseIm;
   rotSample_t negRe;
   rotSample_t negIm;

   // ------------------------------------------------------------------------
   // truncation
   // ------------------------------------------------------------------------
   // half scale keeps one bit less and repeats the sign, so the zero branch
   // sits at half the level of the plus and minus branches
   always_comb begin
      if (HalfScale) begin
         baseRe = {re[SampleWidth-1], re[SampleWidth-1 -: RotWidth-1]};
         baseIm = {im[SampleWidth-1], im[SampleWidth-1 -: RotWidth-1]};
      end else begin
         baseRe = re[SampleWidth-1 -: RotWidth];
         baseIm = im[SampleWidth-1 -: RotWidth];
      end
   end

   // negation wraps in RotWidth bits
   assign negRe = -baseRe;
   assign negIm = -baseIm;

   // ------------------------------------------------------------------------
   // rotations, registered on the strobe
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         rotReal <= '0;
         rotImag <= '0;
      end else if (sampleEn) begin
         // rotation 0, (re, im)
         rotReal[0] <= baseRe;
         rotImag[0] <= baseIm;
         // rotation 1, (im, -re)
         rotReal[1] <= baseIm;
         rotImag[1] <= negRe;
         // rotation 2, (-re, -im)
         rotReal[2] <= negRe;
         rotImag[2] <= negIm;
         // rotation 3, (-im, re)
         rotReal[3] <= negIm;
         rotImag[3] <= baseRe;
      end
   end

endmodule

/* rtl/dacChannelMux.sv */
/* DAC monitor channel
   registers one of I, Q, phase error or trellis index for a test DAC */

`timescale 1ns/1ps

module dacChannelMux
   import trellisPkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          sampleEn,
   input  dacSel_t       dacSelect,
   input  sample_t       iIn,
   input  sample_t       qIn,
   input  phErr_t        phaseErr,
   input  trellisIndex_t index,
   output sample_t       dacData,
   output logic          dacSync
);

   sample_t phErrForm;
   sample_t indexForm;

   // phase error left justified on the DAC
   assign phErrForm = {phaseErr, {(SampleWidth-PhErrWidth){1'b0}}};

   // index just below the sign bit, so it always shows positive
   assign indexForm = {1'b0, index, {(SampleWidth-3){1'b0}}};

   always_ff @(posedge clk) begin
      case (dacSelect)
         DacSelI:     dacData <= iIn;
         DacSelQ:     dacData <= qIn;
         DacSelPhErr: dacData <= phErrForm;
         DacSelIndex: dacData <= indexForm;
         default:     dacData <= phErrForm;
      endcase
   end

   // sync pulse tracks the data register
   always_ff @(posedge clk) begin
      if (rst)
         dacSync <= 1'b0;
      else
         dacSync <= sampleEn;
   end

endmodule

/* rtl/phaseErrorScaler.sv */
/* Phase error scaler
   doubles the decoder phase error into eight bits with saturation */

`timescale 1ns/1ps

module phaseErrorScaler
   import trellisPkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         sampleEn,
   input  phErr_t       phaseErr,
   output phErrScaled_t phErrScaled
);

   logic         signBit;
   phErrScaled_t shifted;
   logic         satPos;
   logic         satNeg;

   assign signBit = phaseErr[PhErrWidth-1];

   // stage one captures the doubled value and the overflow flags
   // anything above bit 6 that differs from the sign cannot fit after doubling
   always_ff @(posedge clk) begin
      if (rst) begin
         shifted <= '0;
         satPos  <= 1'b0;
         satNeg  <= 1'b0;
      end else if (sampleEn) begin
         shifted <= {phaseErr[6:0], 1'b0};
         satPos  <= !signBit && (phaseErr[8:6] != 3'b000);
         satNeg  <= signBit && (phaseErr[8:6] != 3'b111);
      end
   end

   // stage two clamps to the symmetric limits
   always_ff @(posedge clk) begin
      if (rst) begin
         phErrScaled <= '0;
      end else if (sampleEn) begin
         if (satPos)
            phErrScaled <= 8'h7F;
         else if (satNeg)
            phErrScaled <= 8'h81;
         else
            phErrScaled <= shifted;
      end
   end

endmodule

/* rtl/trellisFrontEnd.sv */
/* SOQPSK trellis front end
   branch rotation, phase error scaling, decay register and DAC monitors */

`timescale 1ns/1ps

module trellisFrontEnd
   import trellisPkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  sampleEn,
   input  logic                  wrEn,
   input  sample_t               iIn,
   input  sample_t               qIn,
   input  sample_t               mfmI,
   input  sample_t               mfmQ,
   input  sample_t               mfpI,
   input  sample_t               mfpQ,
   input  phErr_t                phaseErr,
   input  trellisIndex_t         index,
   input  regAddr_t              addr,
   input  regData_t              wrData,
   output regData_t              rdData,
   input  dacSel_t               dac0Select,
   input  dacSel_t               dac1Select,
   input  dacSel_t               dac2Select,
   output sample_t               dac0Data,
   output sample_t               dac1Data,
   output sample_t               dac2Data,
   output logic                  dac0Sync,
   output logic                  dac1Sync,
   output logic                  dac2Sync,
   output rotBank_t              zeroReal,
   output rotBank_t              zeroImag,
   output rotBank_t              minusReal,
   output rotBank_t              minusImag,
   output rotBank_t              plusReal,
   output rotBank_t              plusImag,
   output phErrScaled_t          phErrScaled,
   output logic [DecayWidth-1:0] decayFactor,
   output logic                  symEn2xOut
);

   sample_t zeroI;
   sample_t zeroQ;
   logic    sampleEnDly;

   // ------------------------------------------------------------------------
   // matched filter branches
   // ------------------------------------------------------------------------
   zeroBranchAlign zeroAlign (
      .clk      (clk),
      .rst      (rst),
      .sampleEn (sampleEn),
      .iIn      (iIn),
      .qIn      (qIn),
      .zeroI    (zeroI),
      .zeroQ    (zeroQ)
   );

   // zero branch at half scale against the filter outputs
   branchRotator #(.HalfScale(1'b1)) zeroRot (
      .clk      (clk),
      .rst      (rst),
      .sampleEn (sampleEn),
      .re       (zeroI),
      .im       (zeroQ),
      .rotReal  (zeroReal),
      .rotImag  (zeroImag)
   );

   branchRotator #(.HalfScale(1'b0)) minusRot (
      .clk      (clk),
      .rst      (rst),
      .sampleEn (sampleEn),
      .re       (mfmI),
      .im       (mfmQ),
      .rotReal  (minusReal),
      .rotImag  (minusImag)
   );

   branchRotator #(.HalfScale(1'b0)) plusRot (
      .clk      (clk),
      .rst      (rst),
      .sampleEn (sampleEn),
      .re       (mfpI),
      .im       (mfpQ),
      .rotReal  (plusReal),
      .rotImag  (plusImag)
   );

   // ------------------------------------------------------------------------
   // decoder feedback and control
   // ------------------------------------------------------------------------
   phaseErrorScaler phErrScale (
      .clk         (clk),
      .rst         (rst),
      .sampleEn    (sampleEn),
      .phaseErr    (phaseErr),
      .phErrScaled (phErrScaled)
   );

   trellisRegisters regs (
      .clk         (clk),
      .rst         (rst),
      .wrEn        (wrEn),
      .addr        (addr),
      .wrData      (wrData),
      .rdData      (rdData),
      .decayFactor (decayFactor)
   );

   // two cycle wide enable for the line decoder, strobes are >= 4 clocks apart
   always_ff @(posedge clk) begin
      if (rst)
         sampleEnDly <= 1'b0;
      else
         sampleEnDly <= sampleEn;
   end

   assign symEn2xOut = sampleEn | sampleEnDly;

   // ------------------------------------------------------------------------
   // DAC monitors
   // ------------------------------------------------------------------------
   dacChannelMux dac0Mux (
      .clk       (clk),
      .rst       (rst),
      .sampleEn  (sampleEn),
      .dacSelect (dac0Select),
      .iIn       (iIn),
      .qIn       (qIn),
      .phaseErr  (phaseErr),
      .index     (index),
      .dacData   (dac0Data),
      .dacSync   (dac0Sync)
   );

   dacChannelMux dac1Mux (
      .clk       (clk),
      .rst       (rst),
      .sampleEn  (sampleEn),
      .dacSelect (dac1Select),
      .iIn       (iIn),
      .qIn       (qIn),
      .phaseErr  (phaseErr),
      .index     (index),
      .dacData   (dac1Data),
      .dacSync   (dac1Sync)
   );

   dacChannelMux dac2Mux (
      .clk       (clk),
      .rst       (rst),
      .sampleEn  (sampleEn),
      .dacSelect (dac2Select),
      .iIn       (iIn),
      .qIn       (qIn),
      .phaseErr  (phaseErr),
      .index     (index),
      .dacData   (dac2Data),
      .dacSync   (dac2Sync)
   );

endmodule

/* rtl/trellisPkg.sv */
/* Trellis front end shared definitions
   widths, sample types, DAC monitor select codes and register addresses */

package trellisPkg;

   // -------------------------------------------------------------------------
   // widths
   // -------------------------------------------------------------------------
   localparam int SampleWidth   = 18;
   localparam int RotWidth      = 10;
   localparam int PhErrWidth    = 10;
   localparam int PhErrOutWidth = 8;
   localparam int DecayWidth    = 8;

   // zero branch stands in for the matched filter latency
   localparam int ZeroAlignDepth = 3;

   // decay factor after reset, full persistence
   localparam logic [DecayWidth-1:0] DecayReset = 8'hFF;

   // -------------------------------------------------------------------------
   // sample types
   // -------------------------------------------------------------------------
   typedef logic signed [SampleWidth-1:0] sample_t;

   // one rotated branch component as seen by the decoder
   typedef logic signed [RotWidth-1:0] rotSample_t;

   // four quadrant rotations, index is the rotation number
   typedef rotSample_t [3:0] rotBank_t;

   typedef logic signed [PhErrWidth-1:0]    phErr_t;
   typedef logic signed [PhErrOutWidth-1:0] phErrScaled_t;

   typedef logic [1:0] trellisIndex_t;

   // -------------------------------------------------------------------------
   // DAC monitor select codes
   // -------------------------------------------------------------------------
   typedef logic [3:0] dacSel_t;

   localparam dacSel_t DacSelI     = 4'd0;
   localparam dacSel_t DacSelQ     = 4'd1;
   localparam dacSel_t DacSelPhErr = 4'd2;
   localparam dacSel_t DacSelIndex = 4'd3;

   // -------------------------------------------------------------------------
   // register space
   // -------------------------------------------------------------------------
   typedef logic [12:0] regAddr_t;
   typedef logic [31:0] regData_t;

   localparam regAddr_t TrellisDecayAddr = 13'h0400;

endpackage

/* rtl/trellisRegisters.sv */
/* Trellis register space
   holds the decoder decay factor, synchronous write and combinational read */

`timescale 1ns/1ps

module trellisRegisters
   import trellisPkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  wrEn,
   input  regAddr_t              addr,
   input  regData_t              wrData,
   output regData_t              rdData,
   output logic [DecayWidth-1:0] decayFactor
);

   logic decaySel;

   assign decaySel = (addr == TrellisDecayAddr);

   // ------------------------------------------------------------------------
   // write side
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         decayFactor <= DecayReset;
      end else if (wrEn && decaySel) begin
         decayFactor <= wrData[DecayWidth-1:0];
      end
   end

   // ------------------------------------------------------------------------
   // read side
   // ------------------------------------------------------------------------
   // unmapped addresses read back as zero
   always_comb begin
      rdData = '0;
      if (decaySel) begin
         rdData[DecayWidth-1:0] = decayFactor;
      end
   end

endmodule

/* rtl/zeroBranchAlign.sv */
/* Zero branch alignment delay
   holds I/Q for ZeroAlignDepth strobes to match the matched filter latency */

`timescale 1ns/1ps

module zeroBranchAlign
   import trellisPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    sampleEn,
   input  sample_t iIn,
   input  sample_t qIn,
   output sample_t zeroI,
   output sample_t zeroQ
);

   sample_t iLine [ZeroAlignDepth];
   sample_t qLine [ZeroAlignDepth];

   // shift only on the sample strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < ZeroAlignDepth; i++) begin
            iLine[i] <= '0;
            qLine[i] <= '0;
         end
      end else if (sampleEn) begin
         iLine[0] <= iIn;
         qLine[0] <= qIn;
         for (int i = 1; i < ZeroAlignDepth; i++) begin
            iLine[i] <= iLine[i-1];
            qLine[i] <= qLine[i-1];
         end
      end
   end

   // oldest tap feeds the zero branch rotator
   assign zeroI = iLine[ZeroAlignDepth-1];
   assign zeroQ = qLine[ZeroAlignDepth-1];

endmodule

/* sim/trellisFrontEndTb.sv */
/* Trellis front end testbench
   replays stimulus records against a reference model of the branch, scaler and DAC rules */

`timescale 1ns/1ps

module trellisFrontEndTb
   import trellisPkg::*;
();

   localparam int SyncTimeout = 8;
   localparam int RunTimeout  = 20000;

   logic                  clk;
   logic                  rst;
   logic                  sampleEn;
   logic                  wrEn;
   sample_t               iIn, qIn, mfmI, mfmQ, mfpI, mfpQ;
   phErr_t                phaseErr;
   trellisIndex_t         index;
   regAddr_t              addr;
   regData_t              wrData;
   regData_t              rdData;
   dacSel_t               dac0Select, dac1Select, dac2Select;
   sample_t               dac0Data, dac1Data, dac2Data;
   logic                  dac0Sync, dac1Sync, dac2Sync;
   rotBank_t              zeroReal, zeroImag, minusReal, minusImag, plusReal, plusImag;
   phErrScaled_t          phErrScaled;
   logic [DecayWidth-1:0] decayFactor;
   logic                  symEn2xOut;

   // reference model state
   logic [15:0]           lfsr;
   sample_t               histI[$];
   sample_t               histQ[$];
   phErr_t                prevPhErr;
   logic [DecayWidth-1:0] decayModel;
   int                    sampleCount;

   trellisFrontEnd i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // overall run limit
   initial begin
      for (int n = 0; n < RunTimeout; n++)
         @(posedge clk);
      abortRun("run exceeded its cycle limit without finishing the stimulus file");
   end

   // ------------------------------------------------------------------------
   // failure reporting and compares
   // ------------------------------------------------------------------------
   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped on first error");
   endtask

   task automatic checkBank(input string name, input rotBank_t got, input rotBank_t exp);
      if (got !== exp)
         abortRun($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                            $time, name, got, exp));
   endtask

   task automatic checkPhErr(input string name, input phErrScaled_t got,
                             input phErrScaled_t exp);
      if (got !== exp)
         abortRun($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                            $time, name, got, exp));
   endtask

   task automatic checkSample(input string name, input sample_t got, input sample_t exp);
      if (got !== exp)
         abortRun($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                            $time, name, got, exp));
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abortRun($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                            $time, name, got, exp));
   endtask

   task automatic checkReg(input string name, input regData_t got, input regData_t exp);
      if (got !== exp)
         abortRun($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                            $time, name, got, exp));
   endtask

   task automatic waitClocks(input int n);
      for (int c = 0; c < n; c++)
         @(posedge clk);
   endtask

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------
   // taps 16 14 13 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // top bits of the sample with one more bit dropped at half scale
   function automatic rotSample_t branchBase(input sample_t x, input bit half);
      return half ? rotSample_t'(x >>> 9) : rotSample_t'(x >>> 8);
   endfunction

   function automatic rotBank_t realRef(input sample_t re, input sample_t im, input bit half);
      rotSample_t a;
      rotSample_t b;
      a = branchBase(re, half);
      b = branchBase(im, half);
      return {-b, -a, b, a};
   endfunction

   function automatic rotBank_t imagRef(input sample_t re, input sample_t im, input bit half);
      rotSample_t a;
      rotSample_t b;
      a = branchBase(re, half);
      b = branchBase(im, half);
      return {a, -b, -a, b};
   endfunction

   // doubling clamps at +127 and -127
   function automatic phErrScaled_t scaleRef(input phErr_t pe);
      int v;
      v = int'(pe);
      if (v > 63)
         return 8'h7F;
      else if (v < -64)
         return 8'h81;
      else
         return phErrScaled_t'(2 * v);
   endfunction

   function automatic sample_t dacRef(input dacSel_t sel);
      case (sel)
         DacSelI:     return iIn;
         DacSelQ:     return qIn;
         DacSelIndex: return sample_t'(int'(index) * 32768);
         default:     return sample_t'(int'(phaseErr) * 256);
      endcase
   endfunction

   // ------------------------------------------------------------------------
   // record handlers
   // ------------------------------------------------------------------------
   task automatic runSample(input string rec);
      logic [31:0] v[8];
      int          n;
      int          gapCycles;
      if ($sscanf(rec, "%h %h %h %h %h %h %h %h",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]) != 8)
         abortRun("malformed sample record in the stimulus file");
      @(posedge clk);
      sampleEn <= 1'b1;
      iIn      <= v[0][SampleWidth-1:0];
      qIn      <= v[1][SampleWidth-1:0];
      mfmI     <= v[2][SampleWidth-1:0];
      mfmQ     <= v[3][SampleWidth-1:0];
      mfpI     <= v[4][SampleWidth-1:0];
      mfpQ     <= v[5][SampleWidth-1:0];
      phaseErr <= v[6][PhErrWidth-1:0];
      index    <= v[7][1:0];
      @(negedge clk);
      checkBit("symEn2xOut", symEn2xOut, 1'b1);
      checkBit("dac0Sync", dac0Sync, 1'b0);
      checkBit("dac1Sync", dac1Sync, 1'b0);
      checkBit("dac2Sync", dac2Sync, 1'b0);
      @(posedge clk);
      sampleEn <= 1'b0;
      // sync marks the cycle after the strobe
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (dac0Sync !== 1'b1 && n < SyncTimeout);
      if (dac0Sync !== 1'b1)
         abortRun("dac0Sync never rose after the sample strobe");
      checkBit("dac0Sync latency", n == 1, 1'b1);
      checkBit("dac1Sync", dac1Sync, 1'b1);
      checkBit("dac2Sync", dac2Sync, 1'b1);
      checkBit("symEn2xOut", symEn2xOut, 1'b1);
      checkBank("minusReal", minusReal, realRef(mfmI, mfmQ, 1'b0));
      checkBank("minusImag", minusImag, imagRef(mfmI, mfmQ, 1'b0));
      checkBank("plusReal", plusReal, realRef(mfpI, mfpQ, 1'b0));
      checkBank("plusImag", plusImag, imagRef(mfpI, mfpQ, 1'b0));
      // zero branch lags by the alignment depth
      checkBank("zeroReal", zeroReal, realRef(histI[0], histQ[0], 1'b1));
      checkBank("zeroImag", zeroImag, imagRef(histI[0], histQ[0], 1'b1));
      void'(histI.pop_front());
      void'(histQ.pop_front());
      histI.push_back(iIn);
      histQ.push_back(qIn);
      checkPhErr("phErrScaled", phErrScaled, scaleRef(prevPhErr));
      prevPhErr = phaseErr;
      checkSample("dac0Data", dac0Data, dacRef(dac0Select));
      checkSample("dac1Data", dac1Data, dacRef(dac1Select));
      checkSample("dac2Data", dac2Data, dacRef(dac2Select));
      // quiet cycles up to the next strobe
      lfsr = lfsrNext(lfsr);
      gapCycles = lfsr[0] ? 3 : 2;
      for (int c = 0; c < gapCycles; c++) begin
         @(negedge clk);
         checkBit("symEn2xOut", symEn2xOut, 1'b0);
         checkBit("dac0Sync", dac0Sync, 1'b0);
         checkBit("dac1Sync", dac1Sync, 1'b0);
         checkBit("dac2Sync", dac2Sync, 1'b0);
      end
      sampleCount++;
   endtask

   task automatic runWrite(input string rec);
      logic [31:0] a;
      logic [31:0] d;
      if ($sscanf(rec, "%h %h", a, d) != 2)
         abortRun("malformed write record in the stimulus file");
      @(posedge clk);
      wrEn   <= 1'b1;
      addr   <= a[12:0];
      wrData <= d;
      @(posedge clk);
      wrEn <= 1'b0;
      if (a[12:0] == TrellisDecayAddr)
         decayModel = d[DecayWidth-1:0];
      @(negedge clk);
      checkReg("decayFactor", regData_t'(decayFactor), regData_t'(decayModel));
   endtask

   task automatic runRead(input string rec);
      logic [31:0] a;
      logic [31:0] e;
      if ($sscanf(rec, "%h %h", a, e) != 2)
         abortRun("malformed read record in the stimulus file");
      @(posedge clk);
      addr <= a[12:0];
      @(negedge clk);
      checkReg("rdData", rdData, e);
      checkReg("decayFactor", regData_t'(decayFactor), regData_t'(decayModel));
   endtask

   task automatic applySelects(input string rec);
      logic [31:0] s0;
      logic [31:0] s1;
      logic [31:0] s2;
      if ($sscanf(rec, "%h %h %h", s0, s1, s2) != 3)
         abortRun("malformed DAC select record in the stimulus file");
      @(posedge clk);
      dac0Select <= s0[3:0];
      dac1Select <= s1[3:0];
      dac2Select <= s2[3:0];
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      int    fd;
      string line;
      rst        = 1'b1;
      sampleEn   = 1'b0;
      wrEn       = 1'b0;
      iIn        = '0;
      qIn        = '0;
      mfmI       = '0;
      mfmQ       = '0;
      mfpI       = '0;
      mfpQ       = '0;
      phaseErr   = '0;
      index      = '0;
      addr       = '0;
      wrData     = '0;
      dac0Select = DacSelI;
      dac1Select = DacSelI;
      dac2Select = DacSelI;
      lfsr        = 16'd50;
      prevPhErr   = '0;
      decayModel  = DecayReset;
      sampleCount = 0;
      for (int k = 0; k < ZeroAlignDepth; k++) begin
         histI.push_back('0);
         histQ.push_back('0);
      end
      fd = $fopen("sim/trellisStimulus.txt", "r");
      if (fd == 0)
         abortRun("cannot open sim/trellisStimulus.txt");

      waitClocks(10);
      rst <= 1'b0;
      @(negedge clk);
      checkBank("zeroReal", zeroReal, '0);
      checkBank("zeroImag", zeroImag, '0);
      checkBank("minusReal", minusReal, '0);
      checkBank("minusImag", minusImag, '0);
      checkBank("plusReal", plusReal, '0);
      checkBank("plusImag", plusImag, '0);
      checkPhErr("phErrScaled", phErrScaled, '0);
      checkReg("decayFactor", regData_t'(decayFactor), regData_t'(DecayReset));
      checkBit("symEn2xOut", symEn2xOut, 1'b0);
      checkBit("dac0Sync", dac0Sync, 1'b0);

      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line[0] == "#")
            continue;
         case (line[0])
            "S":     runSample(line.substr(2, line.len() - 1));
            "W":     runWrite(line.substr(2, line.len() - 1));
            "R":     runRead(line.substr(2, line.len() - 1));
            "D":     applySelects(line.substr(2, line.len() - 1));
            default: abortRun($sformatf("unknown stimulus record %s", line));
         endcase
      end
      $fclose(fd);

      if (sampleCount == 0) begin
         abortRun("the stimulus file held no sample records");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

/* sim/trellisStimulus.txt */
# S iIn qIn mfmI mfmQ mfpI mfpQ phaseErr index, D dac0Sel dac1Sel dac2Sel (all hex)
# W addr data, R addr expectedData (all hex)
R 0400 000000FF
R 0123 00000000
D 0 1 2
S 00100 3FF00 1FFFF 20000 00A5C 3F5A4 01F 0
S 20000 1FFFF 20000 20000 1FFFF 1FFFF 040 1
S 3FFFF 00001 12345 2ABCD 0F0F0 30F0F 3BF 2
S 15555 2AAAA 00000 3FFFF 20001 1FE00 000 3
W 0400 0000005A
R 0400 0000005A
R 0401 00000000
D 3 2 1
S 0C000 34000 1C71C 238E4 00200 3FE00 1FF 1
S 2468A 1357B 3E000 02000 20000 00000 200 0
S 1FFFF 20000 05A5A 3A5A6 1FFFF 20000 03F 2
S 00000 00000 11111 2EEEF 08000 38000 3C0 3
D 7 0 3
S 0ABCD 35433 23456 1CBA9 27FFF 18001 3E0 2
S 3C3C3 03C3D 20000 1FFFF 00400 3FC00 1C0 1
W 0400 12345681
R 0400 00000081
W 1400 000000AA
R 1400 00000000
R 0400 00000081
D F 3 0
S 20000 20000 00080 3FF80 1C000 24000 041 3
S 1E000 22000 2FFFF 10000 00001 3FFFF 3BE 0
S 00000 00000 00000 00000 00000 00000 000 0
S 00000 00000 00000 00000 00000 00000 000 0
S 00000 00000 00000 00000 00000 00000 000 0

/* sources.f */
rtl/trellisPkg.sv
rtl/zeroBranchAlign.sv
rtl/branchRotator.sv
rtl/phaseErrorScaler.sv
rtl/trellisRegisters.sv
rtl/dacChannelMux.sv
rtl/trellisFrontEnd.sv
sim/trellisFrontEndTb.sv
